//--- source/qnode_pkg.sv
//--------------------------------------------------------------------------
// widths, field types and enums of the LRWait/SCWait queue node
// successor metadata must fit into one data word (meta width <= data_width)
//--------------------------------------------------------------------------
package qnode_pkg;

  // channel widths, same on core and interconnect side
  localparam int addr_width    = 32;
  localparam int data_width    = 32;
  // transaction id, matches responses to requests
  localparam int meta_id_width = 4;
  // successor metadata carried in the low bits of a data word
  localparam int default_meta_width = 12;

  typedef logic [addr_width-1:0]    addr_t;
  typedef logic [data_width-1:0]    data_t;
  typedef logic [data_width/8-1:0]  strb_t;
  typedef logic [meta_id_width-1:0] meta_id_t;

  // atomic opcodes as seen on the request channel
  typedef enum logic [3:0] {
    AMO_NONE = 4'h0,
    SWAP     = 4'h1,
    ADD      = 4'h2,
    AND      = 4'h3,
    OR       = 4'h4,
    XOR      = 4'h5,
    MAX      = 4'h6,
    MAXU     = 4'h7,
    MIN      = 4'h8,
    MINU     = 4'h9,
    LR       = 4'hA,
    SC       = 4'hB,
    LRWAIT   = 4'hC,
    SCWAIT   = 4'hD,
    // only passed through, never generated here
    MWAIT    = 4'hE
  } amo_op_e;

  // reservation states of one node
  typedef enum logic [1:0] {
    // no reservation in flight
    IDLE,
    // LRWait answered, waiting for SCWait or a successor
    READY_FOR_SC,
    // successor known, waiting for the SCWait
    IN_QUEUE,
    // lock released, wake-up request on the interconnect
    SEND_WAKEUP
  } qnode_state_e;

endpackage

//--- source/qnode_ifs.sv
//--------------------------------------------------------------------------
// internal links of the queue node, not meant for the top level ports
// meta_width must match on both ends of a link
//--------------------------------------------------------------------------
`timescale 1ns/1ps

// accepted core requests, seen by the state machine
interface qnode_req_if import qnode_pkg::*; ();
  // core request accepted by the interconnect
  logic     fire;
  amo_op_e  amo;
  addr_t    addr;
  meta_id_t id;

  modport source (output fire, output amo, output addr, output id);
  modport sink   (input fire, input amo, input addr, input id);
endinterface

// response events, successor updates split from normal responses
interface qnode_resp_if import qnode_pkg::*; #(
  parameter int meta_width = default_meta_width
) ();
  logic                  succ_valid;
  logic [meta_width-1:0] succ_meta;
  // normal response handed to the core
  logic                  resp_fire;
  meta_id_t              resp_id;

  modport filter (output succ_valid, output succ_meta, output resp_fire, output resp_id);
  modport sink   (input succ_valid, input succ_meta, input resp_fire, input resp_id);
endinterface

// wake-up request from the state machine to the request mux
interface qnode_wake_if import qnode_pkg::*; #(
  parameter int meta_width = default_meta_width
) ();
  logic                  wake_valid;
  addr_t                 wake_addr;
  logic [meta_width-1:0] wake_meta;
  logic                  wake_ready;

  modport fsm      (output wake_valid, output wake_addr, output wake_meta, input wake_ready);
  modport injector (input wake_valid, input wake_addr, input wake_meta, output wake_ready);
endinterface

//--- source/succ_update_filter.sv
//--------------------------------------------------------------------------
// response path, purely combinational
// successor updates are always accepted and never reach the core
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module succ_update_filter import qnode_pkg::*; (
  input  data_t    tile_pdata_i,
  input  logic     tile_perror_i,
  input  meta_id_t tile_pid_i,
  input  logic     tile_plrwait_i,
  input  logic     tile_pvalid_i,
  output logic     tile_pready_o,

  output data_t    snitch_pdata_o,
  output logic     snitch_perror_o,
  output meta_id_t snitch_pid_o,
  output logic     snitch_pvalid_o,
  input  logic     snitch_pready_i,

  qnode_resp_if.filter resp
);

  // lrwait flag on a response marks a successor update
  logic succ_update;

  assign succ_update = tile_plrwait_i;

  // updates are consumed here, so ready follows valid
  assign tile_pready_o   = succ_update ? tile_pvalid_i : snitch_pready_i;

  // core sees nothing of an update, outputs held at zero
  assign snitch_pvalid_o = succ_update ? 1'b0 : tile_pvalid_i;
  assign snitch_pdata_o  = succ_update ? '0   : tile_pdata_i;
  assign snitch_perror_o = succ_update ? 1'b0 : tile_perror_i;
  assign snitch_pid_o    = succ_update ? '0   : tile_pid_i;

  // successor metadata sits in the low data bits
  assign resp.succ_valid = tile_pvalid_i & succ_update;
  assign resp.succ_meta  = tile_pdata_i[$bits(resp.succ_meta)-1:0];

  // only completed handshakes of normal responses count
  assign resp.resp_fire  = tile_pvalid_i & ~succ_update & snitch_pready_i;
  assign resp.resp_id    = tile_pid_i;

endmodule

//--- source/wakeup_injector.sv
//--------------------------------------------------------------------------
// request path, core requests pass through combinationally
// while a wake-up is pending the core is stalled, its id lines are reused
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module wakeup_injector import qnode_pkg::*; #(
  parameter int meta_width = default_meta_width
) (
  input  addr_t    snitch_qaddr_i,
  input  logic     snitch_qwrite_i,
  input  amo_op_e  snitch_qamo_i,
  input  data_t    snitch_qdata_i,
  input  strb_t    snitch_qstrb_i,
  input  meta_id_t snitch_qid_i,
  input  logic     snitch_qvalid_i,
  output logic     snitch_qready_o,

  output addr_t    tile_qaddr_o,
  output logic     tile_qwrite_o,
  output amo_op_e  tile_qamo_o,
  output data_t    tile_qdata_o,
  output strb_t    tile_qstrb_o,
  output meta_id_t tile_qid_o,
  output logic     tile_qlrwait_o,
  output logic     tile_qvalid_o,
  input  logic     tile_qready_i,

  qnode_req_if.source    req,
  qnode_wake_if.injector wake
);

  logic  inject;
  // wake-up payload, metadata zero-extended to a data word
  data_t wake_data;

  assign inject = wake.wake_valid;

  always_comb begin
    wake_data                 = '0;
    wake_data[meta_width-1:0] = wake.wake_meta;
  end

  // core blocked for the whole wake-up, back-pressure included
  assign snitch_qready_o = inject ? 1'b0 : tile_qready_i;

  assign tile_qvalid_o  = inject ? 1'b1      : snitch_qvalid_i;
  assign tile_qaddr_o   = inject ? wake.wake_addr : snitch_qaddr_i;
  assign tile_qwrite_o  = inject ? 1'b0      : snitch_qwrite_i;
  assign tile_qamo_o    = inject ? LRWAIT    : snitch_qamo_i;
  assign tile_qdata_o   = inject ? wake_data : snitch_qdata_i;
  assign tile_qstrb_o   = inject ? '0        : snitch_qstrb_i;
  assign tile_qid_o     = snitch_qid_i;
  assign tile_qlrwait_o = inject;

  // wake-up completes on the interconnect handshake
  assign wake.wake_ready = tile_qready_i;

  // report accepted core requests only, never the wake-up itself
  assign req.fire = snitch_qvalid_i & tile_qready_i & ~inject;
  assign req.amo  = snitch_qamo_i;
  assign req.addr = snitch_qaddr_i;
  assign req.id   = snitch_qid_i;

endmodule

//--- source/reservation_fsm.sv
//--------------------------------------------------------------------------
// reservation state machine for one LRWait/SCWait pair in flight at a time
// an SCWait must target the address of the preceding LRWait
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module reservation_fsm import qnode_pkg::*; #(
  parameter int meta_width = default_meta_width
) (
  input logic clk_i,
  input logic rst_i,

  qnode_req_if.sink  req,
  qnode_resp_if.sink resp,
  qnode_wake_if.fsm  wake
);

  qnode_state_e state_q, state_d;

  // next-node record
  logic                  rec_valid_q, rec_valid_d;
  logic [meta_width-1:0] rec_meta_q, rec_meta_d;
  meta_id_t              rec_id_q, rec_id_d;
  addr_t                 rec_addr_q, rec_addr_d;

  // SCWait of the current round already sent
  logic sc_arrived_q, sc_arrived_d;

  logic lr_accept;
  logic sc_match;
  logic resp_match;

  assign lr_accept  = req.fire && (req.amo == LRWAIT);
  // SCWait to the reserved address
  assign sc_match   = req.fire && (req.amo == SCWAIT) && rec_valid_q &&
                      (req.addr == rec_addr_q);
  assign resp_match = resp.resp_fire && rec_valid_q && (resp.resp_id == rec_id_q);

  always_comb begin
    state_d      = state_q;
    rec_valid_d  = rec_valid_q;
    rec_meta_d   = rec_meta_q;
    rec_id_d     = rec_id_q;
    rec_addr_d   = rec_addr_q;
    sc_arrived_d = sc_arrived_q;

    case (state_q)
      IDLE: begin
        if (lr_accept) begin
          rec_id_d    = req.id;
          rec_addr_d  = req.addr;
          rec_valid_d = 1'b1;
        end
        // update may overtake the LRWait response
        if (resp.succ_valid) begin
          rec_meta_d = resp.succ_meta;
          state_d    = IN_QUEUE;
        end else if (resp_match) begin
          state_d = READY_FOR_SC;
        end
      end
      READY_FOR_SC: begin
        if (sc_match) begin
          rec_id_d     = req.id;
          sc_arrived_d = 1'b1;
        end
        // SCWait in this same cycle counts as arrived
        if (resp.succ_valid) begin
          rec_meta_d = resp.succ_meta;
          state_d    = (sc_arrived_q || sc_match) ? SEND_WAKEUP : IN_QUEUE;
        end else if (resp_match && sc_arrived_q) begin
          // SCWait answered without a successor releases the lock
          rec_valid_d  = 1'b0;
          sc_arrived_d = 1'b0;
          state_d      = IDLE;
        end
      end
      IN_QUEUE: begin
        if (sc_match) begin
          state_d = SEND_WAKEUP;
        end
      end
      SEND_WAKEUP: begin
        // record kept stable until the interconnect takes the wake-up
        if (wake.wake_ready) begin
          rec_valid_d  = 1'b0;
          sc_arrived_d = 1'b0;
          state_d      = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign wake.wake_valid = (state_q == SEND_WAKEUP);
  assign wake.wake_addr  = rec_addr_q;
  assign wake.wake_meta  = rec_meta_q;

  // control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= IDLE;
      rec_valid_q  <= 1'b0;
      sc_arrived_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      rec_valid_q  <= rec_valid_d;
      sc_arrived_q <= sc_arrived_d;
    end
  end

  // record payload
  always_ff @(posedge clk_i) begin
    rec_meta_q <= rec_meta_d;
    rec_id_q   <= rec_id_d;
    rec_addr_q <= rec_addr_d;
  end

endmodule

//--- source/lrwait_qnode.sv
//--------------------------------------------------------------------------
// queue node between one core port and the tile interconnect
// pass-through is combinational, wake-up appears one cycle after release
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module lrwait_qnode import qnode_pkg::*; #(
  parameter int meta_width = default_meta_width
) (
  input  logic     clk_i,
  input  logic     rst_i,

  // core requests
  input  addr_t    snitch_qaddr_i,
  input  logic     snitch_qwrite_i,
  input  amo_op_e  snitch_qamo_i,
  input  data_t    snitch_qdata_i,
  input  strb_t    snitch_qstrb_i,
  input  meta_id_t snitch_qid_i,
  input  logic     snitch_qvalid_i,
  output logic     snitch_qready_o,
  // core responses
  output data_t    snitch_pdata_o,
  output logic     snitch_perror_o,
  output meta_id_t snitch_pid_o,
  output logic     snitch_pvalid_o,
  input  logic     snitch_pready_i,

  // interconnect requests
  output addr_t    tile_qaddr_o,
  output logic     tile_qwrite_o,
  output amo_op_e  tile_qamo_o,
  output data_t    tile_qdata_o,
  output strb_t    tile_qstrb_o,
  output meta_id_t tile_qid_o,
  output logic     tile_qlrwait_o,
  output logic     tile_qvalid_o,
  input  logic     tile_qready_i,
  // interconnect responses, lrwait marks a successor update
  input  data_t    tile_pdata_i,
  input  logic     tile_perror_i,
  input  meta_id_t tile_pid_i,
  input  logic     tile_plrwait_i,
  input  logic     tile_pvalid_i,
  output logic     tile_pready_o
);

  qnode_req_if                              req_if ();
  qnode_resp_if #(.meta_width(meta_width)) resp_if ();
  qnode_wake_if #(.meta_width(meta_width)) wake_if ();

  succ_update_filter u_filter (
    .tile_pdata_i    (tile_pdata_i),
    .tile_perror_i   (tile_perror_i),
    .tile_pid_i      (tile_pid_i),
    .tile_plrwait_i  (tile_plrwait_i),
    .tile_pvalid_i   (tile_pvalid_i),
    .tile_pready_o   (tile_pready_o),
    .snitch_pdata_o  (snitch_pdata_o),
    .snitch_perror_o (snitch_perror_o),
    .snitch_pid_o    (snitch_pid_o),
    .snitch_pvalid_o (snitch_pvalid_o),
    .snitch_pready_i (snitch_pready_i),
    .resp            (resp_if)
  );

  wakeup_injector #(.meta_width(meta_width)) u_injector (
    .snitch_qaddr_i  (snitch_qaddr_i),
    .snitch_qwrite_i (snitch_qwrite_i),
    .snitch_qamo_i   (snitch_qamo_i),
    .snitch_qdata_i  (snitch_qdata_i),
    .snitch_qstrb_i  (snitch_qstrb_i),
    .snitch_qid_i    (snitch_qid_i),
    .snitch_qvalid_i (snitch_qvalid_i),
    .snitch_qready_o (snitch_qready_o),
    .tile_qaddr_o    (tile_qaddr_o),
    .tile_qwrite_o   (tile_qwrite_o),
    .tile_qamo_o     (tile_qamo_o),
    .tile_qdata_o    (tile_qdata_o),
    .tile_qstrb_o    (tile_qstrb_o),
    .tile_qid_o      (tile_qid_o),
    .tile_qlrwait_o  (tile_qlrwait_o),
    .tile_qvalid_o   (tile_qvalid_o),
    .tile_qready_i   (tile_qready_i),
    .req             (req_if),
    .wake            (wake_if)
  );

  reservation_fsm #(.meta_width(meta_width)) u_fsm (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req   (req_if),
    .resp  (resp_if),
    .wake  (wake_if)
  );

endmodule

//--- verification/tb_clk_gen.sv
//--------------------------------------------------------------------------
// free-running testbench clock and a synchronous active-high reset
// reset is released on a falling edge, after reset_cycles rising edges
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    // release away from the active edge
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- verification/tb_lrwait_qnode.sv
//--------------------------------------------------------------------------
// queue node testbench with inputs changing on the falling clock edge
// outputs are compared on every rising edge once reset is released
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_lrwait_qnode import qnode_pkg::*; ();

  localparam int meta_w = 12;
  // 40 plain rounds of at most ~10 cycles plus five short lock rounds and margin
  localparam int max_cycles = 2000;

  typedef struct packed {
    logic     valid;
    logic     lrwait;
    logic     write;
    amo_op_e  amo;
    addr_t    addr;
    data_t    data;
    strb_t    strb;
    meta_id_t id;
  } req_t;

  logic clk_i, rst_i;
  addr_t    snitch_qaddr_i, tile_qaddr_o;
  logic     snitch_qwrite_i, snitch_qvalid_i, snitch_qready_o, snitch_perror_o;
  amo_op_e  snitch_qamo_i, tile_qamo_o;
  data_t    snitch_qdata_i, snitch_pdata_o, tile_qdata_o, tile_pdata_i;
  strb_t    snitch_qstrb_i, tile_qstrb_o;
  meta_id_t snitch_qid_i, snitch_pid_o, tile_qid_o, tile_pid_i;
  logic     snitch_pvalid_o, snitch_pready_i, tile_qwrite_o, tile_qlrwait_o;
  logic     tile_qvalid_o, tile_qready_i, tile_perror_i, tile_plrwait_i;
  logic     tile_pvalid_i, tile_pready_o;

  integer seed = 9;
  int     cycles = 0;
  // wake-up the node must present right now
  logic              wake_exp = 1'b0;
  addr_t             wake_addr_exp;
  logic [meta_w-1:0] wake_meta_exp;

  tb_clk_gen clk_gen (.clk_o(clk_i), .rst_o(rst_i));

  lrwait_qnode #(.meta_width(meta_w)) dut_i (.*);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  // core request passes through unless a wake-up is due
  function automatic req_t expect_request();
    req_t r;
    if (wake_exp) begin
      r.valid  = 1'b1;
      r.lrwait = 1'b1;
      r.write  = 1'b0;
      r.amo    = LRWAIT;
      r.addr   = wake_addr_exp;
      r.data   = '0;
      r.data[meta_w-1:0] = wake_meta_exp;
      r.strb   = '0;
    end else begin
      r.valid  = snitch_qvalid_i;
      r.lrwait = 1'b0;
      r.write  = snitch_qwrite_i;
      r.amo    = snitch_qamo_i;
      r.addr   = snitch_qaddr_i;
      r.data   = snitch_qdata_i;
      r.strb   = snitch_qstrb_i;
    end
    // id lines always come from the core
    r.id = snitch_qid_i;
    return r;
  endfunction

  task automatic check_req(input req_t exp, input amo_op_e amo, input addr_t addr,
                           input data_t data, input strb_t strb, input meta_id_t id,
                           input logic write, input logic lrwait, input logic valid);
    if (amo !== exp.amo || addr !== exp.addr || data !== exp.data || strb !== exp.strb ||
        id !== exp.id || write !== exp.write || lrwait !== exp.lrwait ||
        valid !== exp.valid)
      report_failure({
        $sformatf("mismatch at %0t: request %s a=%h d=%h s=%h id=%h w=%b lw=%b v=%b",
                  $time, amo.name(), addr, data, strb, id, write, lrwait, valid),
        $sformatf(", expected %s a=%h d=%h s=%h id=%h w=%b lw=%b v=%b",
                  exp.amo.name(), exp.addr, exp.data, exp.strb, exp.id, exp.write,
                  exp.lrwait, exp.valid)});
  endtask

  task automatic check_resp(input data_t data, input meta_id_t id, input logic error,
                            input logic valid, input data_t exp_data, input meta_id_t exp_id,
                            input logic exp_error, input logic exp_valid);
    if (data !== exp_data || id !== exp_id || error !== exp_error || valid !== exp_valid)
      report_failure($sformatf(
        "mismatch at %0t: response d=%h id=%h err=%b v=%b, expected d=%h id=%h err=%b v=%b",
        $time, data, id, error, valid, exp_data, exp_id, exp_error, exp_valid));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, name, got, exp));
  endtask

  // wake-up expected from the next rising edge on and held by back-pressure
  task automatic arm_wakeup(input logic on);
    if (on) begin
      wake_exp      = 1'b1;
      tile_qready_i = 1'b0;
    end
  endtask

  task automatic send_req(input amo_op_e amo, input addr_t addr, input meta_id_t id,
                          input logic bp, input logic wake_next);
    logic [31:0] rnd;
    @(negedge clk_i);
    rnd = $random(seed);
    snitch_qamo_i   = amo;
    snitch_qaddr_i  = addr;
    snitch_qid_i    = id;
    snitch_qdata_i  = $random(seed);
    snitch_qstrb_i  = rnd[3:0];
    snitch_qwrite_i = (amo == AMO_NONE) & rnd[4];
    snitch_qvalid_i = 1'b1;
    tile_qready_i   = ~bp | rnd[5];
    @(posedge clk_i);
    while (snitch_qready_o !== 1'b1) begin
      @(negedge clk_i);
      rnd = $random(seed);
      tile_qready_i = ~bp | rnd[0];
      @(posedge clk_i);
    end
    @(negedge clk_i);
    snitch_qvalid_i = 1'b0;
    tile_qready_i   = 1'b1;
    arm_wakeup(wake_next);
  endtask

  task automatic send_resp(input data_t data, input meta_id_t id, input logic err,
                           input logic upd, input logic bp, input logic wake_next);
    logic [31:0] rnd;
    @(negedge clk_i);
    rnd = $random(seed);
    tile_pdata_i    = data;
    tile_pid_i      = id;
    tile_perror_i   = err;
    tile_plrwait_i  = upd;
    tile_pvalid_i   = 1'b1;
    snitch_pready_i = ~bp | rnd[0];
    @(posedge clk_i);
    while (tile_pready_o !== 1'b1) begin
      @(negedge clk_i);
      rnd = $random(seed);
      snitch_pready_i = ~bp | rnd[0];
      @(posedge clk_i);
    end
    @(negedge clk_i);
    tile_pvalid_i   = 1'b0;
    tile_plrwait_i  = 1'b0;
    snitch_pready_i = 1'b1;
    arm_wakeup(wake_next);
  endtask

  // called on a falling edge right after arm_wakeup
  task automatic finish_wakeup(input int stall);
    repeat (stall) @(negedge clk_i);
    tile_qready_i = 1'b1;
    @(negedge clk_i);
    wake_exp = 1'b0;
  endtask

  task automatic plain_round();
    logic [31:0] rnd;
    logic [3:0]  code;
    rnd  = $random(seed);
    // opcodes below LRWAIT only
    code = 4'(rnd % 32'd12);
    send_req(amo_op_e'(code), $random(seed), rnd[7:4], 1'b1, 1'b0);
    send_resp($random(seed), rnd[11:8], rnd[12], 1'b0, 1'b1, 1'b0);
  endtask

  // one reservation round with optional successor and early SCWait
  task automatic lock_round(input int stall, input logic early_sc, input logic has_succ);
    logic [31:0]       rnd;
    addr_t             addr;
    meta_id_t          lr_id, sc_id;
    logic [meta_w-1:0] meta;
    rnd  = $random(seed);
    addr = {rnd[31:2], 2'b00};
    rnd  = $random(seed);
    lr_id = rnd[3:0];
    sc_id = rnd[7:4];
    meta  = rnd[meta_w+7:8];
    wake_addr_exp = addr;
    wake_meta_exp = meta;
    rnd = $random(seed);
    send_req(LRWAIT, addr, lr_id, 1'b0, 1'b0);
    send_resp($random(seed), lr_id, 1'b0, 1'b0, 1'b0, 1'b0);
    if (!has_succ) begin
      send_req(SCWAIT, addr, sc_id, 1'b0, 1'b0);
      // matching SCWait response releases the lock so no wake-up may follow
      send_resp($random(seed), sc_id, 1'b0, 1'b0, 1'b0, 1'b0);
      repeat (4) @(negedge clk_i);
    end else if (early_sc) begin
      send_req(SCWAIT, addr, sc_id, 1'b0, 1'b0);
      send_resp({rnd[31:meta_w], meta}, rnd[3:0], 1'b0, 1'b1, 1'b0, 1'b1);
      finish_wakeup(stall);
      send_resp($random(seed), sc_id, 1'b0, 1'b0, 1'b0, 1'b0);
    end else begin
      send_resp({rnd[31:meta_w], meta}, rnd[3:0], 1'b0, 1'b1, 1'b0, 1'b0);
      send_req(SCWAIT, addr, sc_id, 1'b0, 1'b1);
      finish_wakeup(stall);
      send_resp($random(seed), sc_id, 1'b0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  always @(posedge clk_i) begin : compare
    data_t    exp_pdata;
    meta_id_t exp_pid;
    logic     exp_perror, exp_pvalid, exp_pready;
    if (!rst_i) begin
      check_req(expect_request(), tile_qamo_o, tile_qaddr_o, tile_qdata_o, tile_qstrb_o,
                tile_qid_o, tile_qwrite_o, tile_qlrwait_o, tile_qvalid_o);
      check_flag("snitch_qready_o", snitch_qready_o, wake_exp ? 1'b0 : tile_qready_i);
      // successor updates are swallowed and core outputs held at zero
      if (tile_plrwait_i) begin
        exp_pdata  = '0;
        exp_pid    = '0;
        exp_perror = 1'b0;
        exp_pvalid = 1'b0;
        exp_pready = tile_pvalid_i;
      end else begin
        exp_pdata  = tile_pdata_i;
        exp_pid    = tile_pid_i;
        exp_perror = tile_perror_i;
        exp_pvalid = tile_pvalid_i;
        exp_pready = snitch_pready_i;
      end
      check_resp(snitch_pdata_o, snitch_pid_o, snitch_perror_o, snitch_pvalid_o,
                 exp_pdata, exp_pid, exp_perror, exp_pvalid);
      check_flag("tile_pready_o", tile_pready_o, exp_pready);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
      report_failure($sformatf("timeout: tests did not finish within %0d cycles", max_cycles));
  end

  initial begin : stimulus
    snitch_qaddr_i  = '0;
    snitch_qwrite_i = 1'b0;
    snitch_qamo_i   = AMO_NONE;
    snitch_qdata_i  = '0;
    snitch_qstrb_i  = '0;
    snitch_qid_i    = '0;
    snitch_qvalid_i = 1'b0;
    snitch_pready_i = 1'b1;
    tile_qready_i   = 1'b1;
    tile_pdata_i    = '0;
    tile_perror_i   = 1'b0;
    tile_pid_i      = '0;
    tile_plrwait_i  = 1'b0;
    tile_pvalid_i   = 1'b0;
    @(negedge rst_i);
    repeat (20) plain_round();
    // queued wake-up and then one held off by the interconnect
    lock_round(1, 1'b0, 1'b1);
    lock_round(6, 1'b0, 1'b1);
    repeat (10) plain_round();
    // update arrives after SCWait but before its response
    lock_round(2, 1'b1, 1'b1);
    // lock released without successor and then a normal round
    lock_round(1, 1'b0, 1'b0);
    lock_round(1, 1'b0, 1'b1);
    repeat (10) plain_round();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tb.f
source/qnode_pkg.sv
source/qnode_ifs.sv
source/succ_update_filter.sv
source/wakeup_injector.sv
source/reservation_fsm.sv
source/lrwait_qnode.sv
verification/tb_clk_gen.sv
verification/tb_lrwait_qnode.sv

//--- run_sim.sh
#!/bin/sh
# build and run the queue node testbench with Verilator
# the result is taken from the simulation log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_lrwait_qnode -o sim_tb

# a failing run exits non-zero, the log is inspected below either way
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
